// ==== source/x86_operand_pkg.sv ====
`default_nettype none

package x86_operand_pkg;

    // operand kind as delivered by the decoder tables
    typedef enum logic [2:0] {
        OP_NONE        = 3'd0,
        OP_REGISTER    = 3'd1,
        OP_SEGMENT     = 3'd2,
        OP_MM_REGISTER = 3'd3,
        OP_MOD_RM      = 3'd4,
        OP_IMMEDIATE   = 3'd5,
        OP_MEMORY      = 3'd6
    } operand_type_e;

    // operand size of the current instruction
    typedef enum logic [1:0] {
        SIZE_BYTE  = 2'd0,
        SIZE_WORD  = 2'd1,
        SIZE_DWORD = 2'd2
    } reg_size_e;

    // general register number, eax .. edi
    typedef logic [2:0] reg_idx_t;

    // mod r/m byte, msb first
    // reg_op is the reg/opcode field
    typedef struct packed {
        logic [1:0] mod;
        reg_idx_t   reg_op;
        reg_idx_t   rm;
    } modrm_t;

    // scale index base byte, msb first
    typedef struct packed {
        logic [1:0] scale;
        reg_idx_t   index;
        reg_idx_t   base;
    } sib_t;

    // byte registers ah..bh (4..7) live in the upper half of eax..ebx
    function automatic reg_idx_t sized_reg_index(input reg_idx_t idx, input reg_size_e size);
        if (size == SIZE_BYTE) begin
            return {1'b0, idx[1:0]};
        end
        return idx;
    endfunction

endpackage

`default_nettype wire

// ==== source/stall_table_pkg.sv ====
`default_nettype none

package stall_table_pkg;

    // one register access, number plus valid
    typedef struct packed {
        logic                      valid;
        x86_operand_pkg::reg_idx_t num;
    } reg_access_t;

    // up to two reads per operand
    // r0 is the direct register, rm or sib base
    // r1 is only ever the sib index
    typedef struct packed {
        reg_access_t op0_r0;
        reg_access_t op0_r1;
        reg_access_t op1_r0;
        reg_access_t op1_r1;
    } operand_reads_t;

    // esp, used implicitly by push / pop / call / ret
    localparam x86_operand_pkg::reg_idx_t STACK_REG = 3'd4;

endpackage

`default_nettype wire

// ==== source/operand_access_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module operand_access_decode
    import x86_operand_pkg::*, stall_table_pkg::*;
(
    input  reg_size_e      register_size,
    input  operand_type_e  op0,
    input  reg_idx_t       op0_reg,
    input  operand_type_e  op1,
    input  reg_idx_t       op1_reg,
    input  modrm_t         mod_rm,
    input  sib_t           sib,
    output operand_reads_t reads,
    output reg_access_t    write
);

    // register picked by the mod r/m byte, shared by both operands
    reg_idx_t modrm_r0;
    // rm after byte aliasing, only meaningful for mod 11
    reg_idx_t rm_sized;
    // mod 00 rm 101 is disp32 only, no base register
    logic     disp_only;
    // sib present and carrying a real index (100 means none)
    logic     sib_index_used;

    assign rm_sized       = sized_reg_index(mod_rm.rm, register_size);
    assign disp_only      = (mod_rm.mod == 2'b00) && (mod_rm.rm == 3'b101);
    assign sib_index_used = (mod_rm.mod != 2'b11) && (mod_rm.rm == 3'b100)
                            && (sib.index != 3'b100);

    always_comb begin
        if (mod_rm.mod == 2'b11) begin
            // register direct
            modrm_r0 = rm_sized;
        end else if (mod_rm.rm != 3'b100) begin
            // memory through rm as base
            modrm_r0 = mod_rm.rm;
        end else begin
            // rm 100 escapes to the sib base
            modrm_r0 = sib.base;
        end
    end

    // first read of an operand
    function automatic reg_access_t operand_r0(
        input operand_type_e op_type,
        input reg_idx_t      op_reg,
        input reg_size_e     size,
        input reg_idx_t      rm_choice,
        input logic          no_base
    );
        reg_access_t acc;
        acc.valid = 1'b0;
        acc.num   = 3'd0;
        case (op_type)
            OP_REGISTER: begin
                acc.valid = 1'b1;
                acc.num   = sized_reg_index(op_reg, size);
            end
            // memory operands carry an address register, always 32 bit
            OP_MEMORY: begin
                acc.valid = 1'b1;
                acc.num   = op_reg;
            end
            OP_MOD_RM: begin
                acc.valid = !no_base;
                acc.num   = rm_choice;
            end
            default: begin
                acc.valid = 1'b0;
            end
        endcase
        return acc;
    endfunction

    // second read, the sib index
    function automatic reg_access_t operand_r1(
        input operand_type_e op_type,
        input logic          index_used,
        input reg_idx_t      index
    );
        reg_access_t acc;
        acc.valid = (op_type == OP_MOD_RM) && index_used;
        acc.num   = index;
        return acc;
    endfunction

    assign reads.op0_r0 = operand_r0(op0, op0_reg, register_size, modrm_r0, disp_only);
    assign reads.op0_r1 = operand_r1(op0, sib_index_used, sib.index);
    assign reads.op1_r0 = operand_r0(op1, op1_reg, register_size, modrm_r0, disp_only);
    assign reads.op1_r1 = operand_r1(op1, sib_index_used, sib.index);

    // only op0 is a destination
    // register type or mod r/m in register direct form
    always_comb begin
        write.valid = 1'b0;
        write.num   = sized_reg_index(op0_reg, register_size);
        if (op0 == OP_REGISTER) begin
            write.valid = 1'b1;
        end else if ((op0 == OP_MOD_RM) && (mod_rm.mod == 2'b11)) begin
            write.valid = 1'b1;
            write.num   = rm_sized;
        end
    end

endmodule

`default_nettype wire

// ==== source/pending_write_table.sv ====
`timescale 1ns/100ps
`default_nettype none

module pending_write_table
    import x86_operand_pkg::*, stall_table_pkg::*;
#(
    parameter int COUNT_WIDTH = 4
) (
    input  logic                   clk,
    input  logic                   reset,
    input  reg_access_t            write,
    input  reg_idx_t               wb_reg,
    input  reg_size_e              wb_size,
    input  logic                   wb_enable,
    input  logic                   next_stage_ready,
    input  logic                   is_stall,
    output logic [COUNT_WIDTH-1:0] counts [8]
);

    // instruction leaves decode this cycle
    logic     issue;
    // write-back target after byte aliasing
    reg_idx_t wb_idx;
    // per register up / down requests
    logic [7:0] inc;
    logic [7:0] dec;

    assign issue  = next_stage_ready && !is_stall;
    assign wb_idx = sized_reg_index(wb_reg, wb_size);

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            // new writer in flight
            inc[i] = issue && write.valid && (write.num == reg_idx_t'(i));
            // write-back retires one writer, independent of back-pressure
            dec[i] = wb_enable && (wb_idx == reg_idx_t'(i));
        end
    end

    // one counter per general register
    // simultaneous up and down leave it unchanged
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 8; i++) begin
                counts[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 8; i++) begin
                if (inc[i] && !dec[i]) begin
                    counts[i] <= counts[i] + COUNT_WIDTH'(1);
                end else if (dec[i] && !inc[i]) begin
                    counts[i] <= counts[i] - COUNT_WIDTH'(1);
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/read_hazard_check.sv ====
`timescale 1ns/100ps
`default_nettype none

module read_hazard_check
    import stall_table_pkg::*;
#(
    parameter int COUNT_WIDTH = 4
) (
    input  operand_reads_t         reads,
    input  logic                   stack_op,
    input  logic [COUNT_WIDTH-1:0] counts [8],
    output logic                   is_stall
);

    // hit per decoded read
    logic [3:0] read_hit;
    // implicit esp use with esp still being written
    logic       stack_hit;
    // per register, writer still in flight
    logic [7:0] busy;

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            busy[i] = (counts[i] != '0);
        end
    end

    // read names a register that still has a writer in flight
    function automatic logic is_pending(input reg_access_t acc, input logic [7:0] busy_regs);
        return acc.valid && busy_regs[acc.num];
    endfunction

    assign read_hit[0] = is_pending(reads.op0_r0, busy);
    assign read_hit[1] = is_pending(reads.op0_r1, busy);
    assign read_hit[2] = is_pending(reads.op1_r0, busy);
    assign read_hit[3] = is_pending(reads.op1_r1, busy);

    assign stack_hit = stack_op && busy[STACK_REG];

    // combinational in the same cycle as the instruction in decode
    assign is_stall = (|read_hit) || stack_hit;

endmodule

`default_nettype wire

// ==== source/register_access_stall.sv ====
`timescale 1ns/100ps
`default_nettype none

module register_access_stall
    import x86_operand_pkg::*, stall_table_pkg::*;
#(
    parameter int COUNT_WIDTH = 4
) (
    input  logic          clk,
    input  logic          reset,
    input  logic          stack_op,
    input  reg_size_e     register_size,
    input  operand_type_e op0,
    input  reg_idx_t      op0_reg,
    input  operand_type_e op1,
    input  reg_idx_t      op1_reg,
    input  modrm_t        mod_rm,
    input  sib_t          sib,
    input  reg_idx_t      wb_reg,
    input  reg_size_e     wb_size,
    input  logic          wb_enable,
    input  logic          next_stage_ready,
    output logic          is_stall
);

    operand_reads_t         reads;
    reg_access_t            write;
    logic [COUNT_WIDTH-1:0] counts [8];

    // which registers the instruction reads and writes
    operand_access_decode u_decode (
        .register_size (register_size),
        .op0           (op0),
        .op0_reg       (op0_reg),
        .op1           (op1),
        .op1_reg       (op1_reg),
        .mod_rm        (mod_rm),
        .sib           (sib),
        .reads         (reads),
        .write         (write)
    );

    // scoreboard, stall feeds back to block the issue
    pending_write_table #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) u_table (
        .clk              (clk),
        .reset            (reset),
        .write            (write),
        .wb_reg           (wb_reg),
        .wb_size          (wb_size),
        .wb_enable        (wb_enable),
        .next_stage_ready (next_stage_ready),
        .is_stall         (is_stall),
        .counts           (counts)
    );

    read_hazard_check #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) u_hazard (
        .reads    (reads),
        .stack_op (stack_op),
        .counts   (counts),
        .is_stall (is_stall)
    );

endmodule

`default_nettype wire

// ==== test/register_access_stall_assert.sv ====
`timescale 1ns/100ps
`default_nettype none

module register_access_stall_chk
    import x86_operand_pkg::*;
#(
    parameter int COUNT_WIDTH = 4
) (
    input logic                   clk,
    input logic                   reset,
    input logic                   stack_op,
    input reg_size_e              register_size,
    input operand_type_e          op0,
    input reg_idx_t               op0_reg,
    input operand_type_e          op1,
    input reg_idx_t               op1_reg,
    input modrm_t                 mod_rm,
    input sib_t                   sib,
    input reg_idx_t               wb_reg,
    input reg_size_e              wb_size,
    input logic                   wb_enable,
    input logic                   next_stage_ready,
    input logic                   is_stall,
    input logic [COUNT_WIDTH-1:0] counts [8]
);

    // esp
    localparam reg_idx_t ESP = 3'd4;

    int                     error_count = 0;
    logic [COUNT_WIDTH-1:0] ref_counts [8];
    logic                   exp_stall;
    logic                   ref_idle;
    logic                   wr_valid;
    reg_idx_t               wr_num;
    reg_idx_t               wb_num;

    // ah..bh sit in bits 15:8 of eax..ebx
    function automatic reg_idx_t alias_byte(input reg_idx_t num, input reg_size_e size);
        return (size == SIZE_BYTE && num >= 3'd4) ? num - 3'd4 : num;
    endfunction

    // any read of this operand hits a register with a writer in flight
    function automatic logic operand_blocked(input operand_type_e kind, input reg_idx_t num);
        logic     base_read;
        logic     index_read;
        reg_idx_t base_reg;
        base_read = (kind == OP_REGISTER) || (kind == OP_MEMORY);
        base_reg  = (kind == OP_REGISTER) ? alias_byte(num, register_size) : num;
        if (kind == OP_MOD_RM) begin
            // disp32 only form has no base
            base_read = !(mod_rm.mod == 2'b00 && mod_rm.rm == 3'd5);
            if (mod_rm.mod == 2'b11) begin
                base_reg = alias_byte(mod_rm.rm, register_size);
            end else begin
                base_reg = (mod_rm.rm == 3'd4) ? sib.base : mod_rm.rm;
            end
        end
        index_read = (kind == OP_MOD_RM) && (mod_rm.mod != 2'b11) && (mod_rm.rm == 3'd4)
                     && (sib.index != 3'd4);
        return (base_read && ref_counts[base_reg] != '0)
               || (index_read && ref_counts[sib.index] != '0);
    endfunction

    always_comb begin
        exp_stall = operand_blocked(op0, op0_reg) || operand_blocked(op1, op1_reg)
                    || (stack_op && ref_counts[ESP] != '0);
        wr_valid  = (op0 == OP_REGISTER) || (op0 == OP_MOD_RM && mod_rm.mod == 2'b11);
        wr_num    = alias_byte((op0 == OP_REGISTER) ? op0_reg : mod_rm.rm, register_size);
        wb_num    = alias_byte(wb_reg, wb_size);
        ref_idle  = 1'b1;
        for (int i = 0; i < 8; i++) begin
            ref_idle = ref_idle && (ref_counts[i] == '0);
        end
    end

    // model counters, net change is issue minus write-back
    always_ff @(posedge clk) begin
        for (int i = 0; i < 8; i++) begin
            if (reset) begin
                ref_counts[i] <= '0;
            end else begin
                ref_counts[i] <= ref_counts[i]
                    + COUNT_WIDTH'(next_stage_ready && !exp_stall && wr_valid
                                   && wr_num == reg_idx_t'(i))
                    - COUNT_WIDTH'(wb_enable && wb_num == reg_idx_t'(i));
            end
        end
    end

    a_reset_clear: assert property (@(posedge clk) $fell(reset) |-> !is_stall && ref_idle)
        else begin
            error_count++;
            $error("[FAIL] t=%0t is_stall after reset expected 0 got %0b (model idle %0b)",
                   $time, $sampled(is_stall), $sampled(ref_idle));
        end

    a_stall: assert property (@(posedge clk) disable iff (reset) is_stall == exp_stall)
        else begin
            error_count++;
            $error("[FAIL] t=%0t is_stall expected %0b got %0b", $time,
                   $sampled(exp_stall), $sampled(is_stall));
        end

    a_stack: assert property (@(posedge clk) disable iff (reset)
                              stack_op && ref_counts[ESP] != '0 |-> is_stall)
        else begin
            error_count++;
            $error("[FAIL] t=%0t is_stall expected 1 got 0 on a stack op", $time);
        end

    for (genvar g = 0; g < 8; g++) begin : g_reg
        a_count: assert property (@(posedge clk) disable iff (reset)
                                  counts[g] == ref_counts[g])
            else begin
                error_count++;
                $error("[FAIL] t=%0t counts[%0d] expected %0d got %0d", $time, g,
                       $sampled(ref_counts[g]), $sampled(counts[g]));
            end
        // nothing issues under back-pressure or stall
        a_held: assert property (@(posedge clk) disable iff (reset)
                                 !(next_stage_ready && !is_stall) |=> counts[g] <= $past(counts[g]))
            else begin
                error_count++;
                $error("counts[%0d] rose although no instruction issued", g);
            end
    end

endmodule

bind register_access_stall register_access_stall_chk #(
    .COUNT_WIDTH (COUNT_WIDTH)
) u_chk (.*);

`default_nettype wire

// ==== test/register_access_stall_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module register_access_stall_tb
    import x86_operand_pkg::*;
();

    localparam int CLK_PERIOD    = 40;
    localparam int RANDOM_CYCLES = 400;
    // reset plus directed sequences with margin plus the random part
    localparam int TOTAL_CYCLES  = 16 + 60 + RANDOM_CYCLES;

    logic          clk;
    logic          reset;
    logic          stack_op;
    reg_size_e     register_size;
    operand_type_e op0;
    reg_idx_t      op0_reg;
    operand_type_e op1;
    reg_idx_t      op1_reg;
    modrm_t        mod_rm;
    sib_t          sib;
    reg_idx_t      wb_reg;
    reg_size_e     wb_size;
    logic          wb_enable;
    logic          next_stage_ready;
    logic          is_stall;

    // own view of pending writes that steers the random write-backs
    int          pending [8];
    int          wr_target;
    int          wb_target;
    int          cycles;
    logic [31:0] lcg_state;

    register_access_stall #(
        .COUNT_WIDTH (4)
    ) DUT (
        .clk              (clk),
        .reset            (reset),
        .stack_op         (stack_op),
        .register_size    (register_size),
        .op0              (op0),
        .op0_reg          (op0_reg),
        .op1              (op1),
        .op1_reg          (op1_reg),
        .mod_rm           (mod_rm),
        .sib              (sib),
        .wb_reg           (wb_reg),
        .wb_size          (wb_size),
        .wb_enable        (wb_enable),
        .next_stage_ready (next_stage_ready),
        .is_stall         (is_stall)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic idle_inputs();
        stack_op         = 1'b0;
        register_size    = SIZE_DWORD;
        op0              = OP_NONE;
        op0_reg          = '0;
        op1              = OP_NONE;
        op1_reg          = '0;
        mod_rm           = '0;
        sib              = '0;
        wb_reg           = '0;
        wb_size          = SIZE_DWORD;
        wb_enable        = 1'b0;
        next_stage_ready = 1'b1;
        wr_target        = -1;
        wb_target        = -1;
    endtask

    // target is the 32 bit register that the write lands in
    task automatic drive_reg_write(input reg_idx_t num, input reg_size_e size, input int target);
        op0           = OP_REGISTER;
        op0_reg       = num;
        register_size = size;
        wr_target     = target;
    endtask

    task automatic drive_writeback(input reg_idx_t num, input reg_size_e size, input int target);
        wb_enable = 1'b1;
        wb_reg    = num;
        wb_size   = size;
        wb_target = target;
    endtask

    task automatic drive_modrm_read(input logic [1:0] mode, input reg_idx_t rm,
                                    input reg_idx_t base, input reg_idx_t index);
        op1    = OP_MOD_RM;
        mod_rm = {mode, 3'd0, rm};
        sib    = {2'b00, index, base};
    endtask

    task automatic drive_reg_read(input reg_idx_t num);
        op1     = OP_REGISTER;
        op1_reg = num;
    endtask

    // bookkeeping mid cycle and new inputs just after the edge
    task automatic next_cycle();
        @(negedge clk);
        if (wr_target >= 0 && next_stage_ready && !is_stall) begin
            pending[wr_target]++;
        end
        if (wb_enable && wb_target >= 0) begin
            pending[wb_target]--;
        end
        @(posedge clk);
        #2;
        cycles++;
        idle_inputs();
    endtask

    task automatic random_instruction();
        logic [31:0] r;
        logic [31:0] s;
        int          idx;
        lcg_state = lcg_next(lcg_state);
        r         = lcg_state;
        lcg_state = lcg_next(lcg_state);
        s         = lcg_state;
        op0     = (r[2:0] == 3'd7) ? OP_NONE : operand_type_e'(r[2:0]);
        op1     = (r[5:3] == 3'd7) ? OP_NONE : operand_type_e'(r[5:3]);
        op0_reg = r[8:6];
        op1_reg = r[11:9];
        mod_rm  = r[19:12];
        sib     = r[27:20];
        stack_op         = r[28];
        next_stage_ready = r[29] | r[30];
        register_size    = r[31] ? SIZE_BYTE : SIZE_DWORD;
        // writers stay dword so the tracked target is the number itself
        if (op0 == OP_REGISTER) begin
            register_size = SIZE_DWORD;
            wr_target     = int'(op0_reg);
        end else if (op0 == OP_MOD_RM && mod_rm.mod == 2'b11) begin
            register_size = SIZE_DWORD;
            wr_target     = int'(mod_rm.rm);
        end
        if (s[0]) begin
            for (int j = 0; j < 8; j++) begin
                idx = (int'(s[3:1]) + j) % 8;
                if (wb_target < 0 && pending[idx] > 0) begin
                    drive_writeback(reg_idx_t'(idx), SIZE_DWORD, idx);
                end
            end
        end
    endtask

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        cycles    = 0;
        lcg_state = 32'd32359;
        foreach (pending[i]) begin
            pending[i] = 0;
        end
        idle_inputs();
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;
        next_cycle();

        // write ebx and read it back while a second write waits on its own read
        drive_reg_write(3'd3, SIZE_DWORD, 3);
        next_cycle();
        drive_reg_read(3'd3);
        next_cycle();
        drive_reg_write(3'd3, SIZE_DWORD, 3);
        next_cycle();
        drive_reg_read(3'd3);
        drive_writeback(3'd3, SIZE_DWORD, 3);
        next_cycle();
        drive_reg_read(3'd3);
        next_cycle();

        // mod r/m forms against a pending ebp
        drive_reg_write(3'd5, SIZE_DWORD, 5);
        next_cycle();
        drive_modrm_read(2'b01, 3'd4, 3'd5, 3'd2);
        next_cycle();
        drive_modrm_read(2'b01, 3'd4, 3'd1, 3'd5);
        next_cycle();
        drive_modrm_read(2'b00, 3'd5, 3'd5, 3'd5);
        next_cycle();
        drive_writeback(3'd5, SIZE_DWORD, 5);
        next_cycle();

        // ah lands on eax
        drive_reg_write(3'd4, SIZE_BYTE, 0);
        next_cycle();
        drive_reg_read(3'd0);
        next_cycle();
        drive_reg_read(3'd0);
        drive_writeback(3'd4, SIZE_BYTE, 0);
        next_cycle();
        drive_reg_read(3'd0);
        next_cycle();

        // implicit esp use
        stack_op = 1'b1;
        next_cycle();
        drive_reg_write(3'd4, SIZE_DWORD, 4);
        next_cycle();
        stack_op = 1'b1;
        next_cycle();
        // with esp pending a sib index of 100 still reads nothing
        drive_modrm_read(2'b10, 3'd4, 3'd1, 3'd4);
        drive_writeback(3'd4, SIZE_DWORD, 4);
        next_cycle();
        stack_op = 1'b1;
        next_cycle();

        // back-pressure and stall both hold the issue
        drive_reg_write(3'd6, SIZE_DWORD, 6);
        next_stage_ready = 1'b0;
        next_cycle();
        drive_reg_write(3'd2, SIZE_DWORD, 2);
        next_cycle();
        drive_reg_write(3'd7, SIZE_DWORD, 7);
        drive_reg_read(3'd2);
        next_cycle();
        drive_writeback(3'd2, SIZE_DWORD, 2);
        next_cycle();

        repeat (RANDOM_CYCLES) begin
            random_instruction();
            next_cycle();
        end

        $display("cycles %0d, assertion errors %0d", cycles, DUT.u_chk.error_count);
        if (DUT.u_chk.error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(2 * TOTAL_CYCLES * CLK_PERIOD);
        $display("timeout, the stimulus did not finish in the expected time");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== register_access_stall.f ====
source/x86_operand_pkg.sv
source/stall_table_pkg.sv
source/operand_access_decode.sv
source/pending_write_table.sv
source/read_hazard_check.sv
source/register_access_stall.sv
test/register_access_stall_assert.sv
test/register_access_stall_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module register_access_stall_tb \
    -f register_access_stall.f \
    -o sim_register_access_stall

./obj_dir/sim_register_access_stall +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation passed"
